/* files.f */
+incdir+dv
verilog/riscv_v_pkg.sv
verilog/riscv_v_decode_element.sv
verilog/riscv_v_regfile.sv
verilog/riscv_v_lane_alu.sv
verilog/riscv_v_exec_unit.sv
dv/riscv_v_tb.sv

/* Makefile */
# Verilator simulation of the vector execution unit

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f files.f --top-module riscv_v_tb
	./obj_dir/Vriscv_v_tb | tee sim.log
	grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

/* dv/riscv_v_model.svh */
//----------------------------------------------------------
// Reference model for the vector execution unit
// Shadow registers, delayed writes, element-wise results
//----------------------------------------------------------
`ifndef RISCV_V_MODEL_SVH
`define RISCV_V_MODEL_SVH

logic [RISCV_V_DATA_WIDTH-1:0] shadow_regs [RISCV_V_NUM_REGS] = '{default: '0};

// Writes wait for the cycle in which the DUT makes them visible
int                                pend_cycle_q [$];
logic [RISCV_V_REG_ADDR_WIDTH-1:0] pend_addr_q  [$];
logic [RISCV_V_DATA_WIDTH-1:0]     pend_data_q  [$];

task automatic schedule_write(input int at_cycle,
                              input logic [RISCV_V_REG_ADDR_WIDTH-1:0] addr,
                              input logic [RISCV_V_DATA_WIDTH-1:0] data);
    pend_cycle_q.push_back(at_cycle);
    pend_addr_q.push_back(addr);
    pend_data_q.push_back(data);
endtask

task automatic apply_due_writes(input int now);
    logic [RISCV_V_REG_ADDR_WIDTH-1:0] addr;
    while (pend_cycle_q.size() != 0 && pend_cycle_q[0] <= now) begin
        addr = pend_addr_q.pop_front();
        shadow_regs[addr] = pend_data_q.pop_front();
        void'(pend_cycle_q.pop_front());
    end
endtask

// Elements outside [vstart, vl) keep the old destination value
function automatic logic [RISCV_V_DATA_WIDTH-1:0] expected_result(
    input logic [RISCV_V_OP_WIDTH-1:0] op_code,
    input logic [RISCV_V_DATA_WIDTH-1:0] src1_data,
    input logic [RISCV_V_DATA_WIDTH-1:0] src2_data,
    input logic [RISCV_V_DATA_WIDTH-1:0] old_data,
    input int sew, input int len, input int start);
    int                            esize;
    int                            shift;
    logic [RISCV_V_DATA_WIDTH-1:0] mask;
    logic [RISCV_V_DATA_WIDTH-1:0] a;
    logic [RISCV_V_DATA_WIDTH-1:0] b;
    logic [RISCV_V_DATA_WIDTH-1:0] r;
    logic [RISCV_V_DATA_WIDTH-1:0] res;
    esize = 8 << sew;
    mask  = (esize == RISCV_V_DATA_WIDTH) ? '1 : ((128'd1 << esize) - 128'd1);
    res   = old_data;
    for (int i = 0; i < (RISCV_V_NUM_BYTES_DATA >> sew); i++) begin
        if (i >= start && i < len) begin
            shift = i * esize;
            a = (src1_data >> shift) & mask;
            b = (src2_data >> shift) & mask;
            case (op_code)
                ALU_ADD: r = (a + b) & mask;
                ALU_SUB: r = (a - b) & mask;
                ALU_AND: r = a & b;
                ALU_OR:  r = a | b;
                default: r = a ^ b;
            endcase
            res = (res & ~(mask << shift)) | (r << shift);
        end
    end
    return res;
endfunction

`endif

/* dv/riscv_v_tb.sv */
//----------------------------------------------------------
// Testbench for the vector execution unit
// Clock, reset, random stimulus, scoreboard, watchdog
//----------------------------------------------------------

module riscv_v_tb
    import riscv_v_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          CLK_PERIOD   = 100;
    localparam int          RESET_CYCLES = 4;
    localparam logic [31:0] SEED         = 32'h125eaff1;

    // Operations per test, preloads included
    localparam int TOTAL_OPS = 2 + 16 + 48 + 38 + 48 + 88;
    localparam int TIMEOUT_CYCLES = TOTAL_OPS * 3 + RESET_CYCLES + 100;

    logic                              clk;
    logic                              rst_n;
    logic                              wr_valid;
    logic [RISCV_V_REG_ADDR_WIDTH-1:0] wr_addr;
    logic [RISCV_V_DATA_WIDTH-1:0]     wr_data;
    logic                              issue_valid;
    logic [RISCV_V_OP_WIDTH-1:0]       op;
    logic [RISCV_V_REG_ADDR_WIDTH-1:0] vs1;
    logic [RISCV_V_REG_ADDR_WIDTH-1:0] vs2;
    logic [RISCV_V_REG_ADDR_WIDTH-1:0] vd;
    logic [RISCV_V_SEW_WIDTH-1:0]      vsew;
    logic [RISCV_V_VL_WIDTH-1:0]       vl;
    logic [RISCV_V_VL_WIDTH-1:0]       vstart;
    logic                              done;
    logic [RISCV_V_REG_ADDR_WIDTH-1:0] done_vd;
    logic [RISCV_V_DATA_WIDTH-1:0]     done_data;

    int    cycle;
    string test_name;
    int    test_checks;
    int    test_errors;
    int    total_checks;
    int    total_errors;

    // Scoreboard of results still in flight
    int                                exp_cycle_q [$];
    logic [RISCV_V_REG_ADDR_WIDTH-1:0] exp_vd_q    [$];
    logic [RISCV_V_DATA_WIDTH-1:0]     exp_data_q  [$];

    `include "riscv_v_model.svh"

    riscv_v_exec_unit i_riscv_v_exec_unit (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_valid    (wr_valid),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .issue_valid (issue_valid),
        .op          (op),
        .vs1         (vs1),
        .vs2         (vs2),
        .vd          (vd),
        .vsew        (vsew),
        .vl          (vl),
        .vstart      (vstart),
        .done        (done),
        .done_vd     (done_vd),
        .done_data   (done_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Regression failed");
        $finish;
    end

    task automatic compare_value(input string what, input logic [127:0] expv,
                                 input logic [127:0] actv);
        test_checks++;
        assert (actv === expv) else begin
            $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, expv, actv);
            test_errors++;
        end
    endtask

    task automatic check_done();
        int                                e_cycle;
        logic [RISCV_V_REG_ADDR_WIDTH-1:0] e_vd;
        if (done === 1'b1) begin
            test_checks++;
            assert (exp_cycle_q.size() != 0) else begin
                $display("Unexpected done in test %s: no operation was in flight", test_name);
                test_errors++;
            end
            if (exp_cycle_q.size() != 0) begin
                e_cycle = exp_cycle_q.pop_front();
                e_vd = exp_vd_q.pop_front();
                compare_value("done cycle", 128'(e_cycle), 128'(cycle));
                compare_value("done_vd", 128'(e_vd), 128'(done_vd));
                compare_value("done_data", exp_data_q.pop_front(), done_data);
            end
        end else if (exp_cycle_q.size() != 0) begin
            assert (exp_cycle_q[0] > cycle) else begin
                $display("Missing done in test %s: result for v%0d never came", test_name,
                         exp_vd_q[0]);
                test_errors++;
                void'(exp_cycle_q.pop_front());
                void'(exp_vd_q.pop_front());
                void'(exp_data_q.pop_front());
            end
        end
    endtask

    // One falling edge, outputs checked and strobes dropped
    task automatic step();
        @(negedge clk);
        cycle++;
        check_done();
        apply_due_writes(cycle);
        issue_valid = 1'b0;
        wr_valid    = 1'b0;
    endtask

    task automatic drain();
        while (exp_cycle_q.size() != 0) begin
            step();
        end
    endtask

    task automatic preload(input logic [RISCV_V_REG_ADDR_WIDTH-1:0] addr,
                           input logic [RISCV_V_DATA_WIDTH-1:0] data);
        step();
        wr_valid = 1'b1;
        wr_addr  = addr;
        wr_data  = data;
        schedule_write(cycle + 1, addr, data);
    endtask

    // Result due 2 edges later, visible to issues 3 cycles later
    task automatic issue_op(input logic [RISCV_V_OP_WIDTH-1:0] op_code,
                            input logic [RISCV_V_REG_ADDR_WIDTH-1:0] src1,
                            input logic [RISCV_V_REG_ADDR_WIDTH-1:0] src2,
                            input logic [RISCV_V_REG_ADDR_WIDTH-1:0] dst,
                            input logic [RISCV_V_SEW_WIDTH-1:0] sew,
                            input logic [RISCV_V_VL_WIDTH-1:0] len,
                            input logic [RISCV_V_VL_WIDTH-1:0] start);
        logic [RISCV_V_DATA_WIDTH-1:0] expv;
        step();
        expv = expected_result(op_code, shadow_regs[src1], shadow_regs[src2], shadow_regs[dst],
                               int'(sew), int'(len), int'(start));
        exp_cycle_q.push_back(cycle + 2);
        exp_vd_q.push_back(dst);
        exp_data_q.push_back(expv);
        schedule_write(cycle + 3, dst, expv);
        issue_valid = 1'b1;
        op          = op_code;
        vs1         = src1;
        vs2         = src2;
        vd          = dst;
        vsew        = sew;
        vl          = len;
        vstart      = start;
    endtask

    function automatic logic [RISCV_V_DATA_WIDTH-1:0] rand_data();
        return {$urandom(), $urandom(), $urandom(), $urandom()};
    endfunction

    function automatic logic [RISCV_V_REG_ADDR_WIDTH-1:0] rand_reg();
        return RISCV_V_REG_ADDR_WIDTH'($urandom_range(RISCV_V_NUM_REGS - 1, 0));
    endfunction

    function automatic logic [RISCV_V_SEW_WIDTH-1:0] rand_sew();
        return RISCV_V_SEW_WIDTH'($urandom_range(int'(OSIZE_128), 0));
    endfunction

    function automatic logic [RISCV_V_VL_WIDTH-1:0] full_vl(input logic [2:0] sew);
        return RISCV_V_VL_WIDTH'(RISCV_V_NUM_ELEMENTS_REG >> sew);
    endfunction

    task automatic issue_random(input logic [RISCV_V_OP_WIDTH-1:0] op_code, input bit partial,
                                input logic [RISCV_V_REG_ADDR_WIDTH-1:0] src1);
        logic [RISCV_V_SEW_WIDTH-1:0] sew;
        logic [RISCV_V_VL_WIDTH-1:0]  len;
        logic [RISCV_V_VL_WIDTH-1:0]  start;
        sew   = rand_sew();
        len   = full_vl(sew);
        start = '0;
        if (partial) begin
            start = RISCV_V_VL_WIDTH'($urandom_range(int'(len), 0));
            len   = RISCV_V_VL_WIDTH'($urandom_range(int'(len), 0));
        end
        issue_op(op_code, src1, rand_reg(), rand_reg(), sew, len, start);
    endtask

    task automatic preload_all();
        for (int r = 0; r < RISCV_V_NUM_REGS; r++) begin
            preload(RISCV_V_REG_ADDR_WIDTH'(r), rand_data());
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic finish_test();
        drain();
        total_checks += test_checks;
        total_errors += test_errors;
        $display("test %-14s checks %4d errors %0d  %s", test_name, test_checks, test_errors,
                 (test_errors == 0) ? "PASS" : "FAIL");
    endtask

    initial begin
        logic [RISCV_V_REG_ADDR_WIDTH-1:0] last_vd;
        logic [RISCV_V_SEW_WIDTH-1:0]      pre_sew;
        void'($urandom(SEED));
        rst_n       = 1'b0;
        wr_valid    = 1'b0;
        wr_addr     = '0;
        wr_data     = '0;
        issue_valid = 1'b0;
        op          = ALU_ADD;
        vs1         = '0;
        vs2         = '0;
        vd          = '0;
        vsew        = OSIZE_8;
        vl          = '0;
        vstart      = '0;
        repeat (RESET_CYCLES) step();
        rst_n = 1'b1;

        // Idle after reset, then registers never written read as zero
        start_test("reset");
        repeat (3) begin
            step();
            compare_value("done", 128'(0), 128'(done));
        end
        issue_op(ALU_OR, 3'd5, 3'd5, 3'd6, OSIZE_8, full_vl(OSIZE_8), '0);
        issue_op(ALU_XOR, 3'd3, 3'd4, 3'd2, OSIZE_32, full_vl(OSIZE_32), '0);
        finish_test();

        // v7 is all ones, so AND returns each preloaded value
        start_test("preload");
        for (int r = 0; r < RISCV_V_NUM_REGS - 1; r++) begin
            preload(RISCV_V_REG_ADDR_WIDTH'(r), rand_data());
        end
        preload(3'd7, '1);
        for (int r = 0; r < RISCV_V_NUM_REGS; r++) begin
            pre_sew = rand_sew();
            issue_op(ALU_AND, 3'(r), 3'd7, 3'(r), pre_sew, full_vl(pre_sew), '0);
        end
        finish_test();

        start_test("add_sub");
        preload_all();
        for (int s = 0; s <= int'(OSIZE_128); s++) begin
            repeat (4) begin
                issue_op(ALU_ADD, rand_reg(), rand_reg(), rand_reg(), 3'(s), full_vl(3'(s)), '0);
                issue_op(ALU_SUB, rand_reg(), rand_reg(), rand_reg(), 3'(s), full_vl(3'(s)), '0);
            end
        end
        finish_test();

        start_test("logic");
        preload_all();
        repeat (30) issue_random(3'($urandom_range(int'(ALU_XOR), int'(ALU_AND))), 0, rand_reg());
        finish_test();

        start_test("tail_prestart");
        preload_all();
        repeat (40) issue_random(3'($urandom_range(int'(ALU_XOR), 0)), 1, rand_reg());
        finish_test();

        // Half of the ops read the previous destination
        start_test("back_to_back");
        preload_all();
        last_vd = '0;
        repeat (80) begin
            issue_random(3'($urandom_range(int'(ALU_XOR), 0)), 1,
                         ($urandom_range(1, 0) == 1) ? last_vd : rand_reg());
            last_vd = vd;
        end
        finish_test();

        $display("checks %0d errors %0d", total_checks, total_errors);
        if (total_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule : riscv_v_tb

/* verilog/riscv_v_exec_unit.sv */
//----------------------------------------------------------
// Vector execution unit top with two pipeline stages
// Issue read, ALU, tail/prestart undisturbed writeback
//----------------------------------------------------------

module riscv_v_exec_unit
    import riscv_v_pkg::*;
(
    input  logic                              clk,
    input  logic                              rst_n,

    // Preload port
    input  logic                              wr_valid,
    input  logic [RISCV_V_REG_ADDR_WIDTH-1:0] wr_addr,
    input  logic [RISCV_V_DATA_WIDTH-1:0]     wr_data,

    // Issue port
    input  logic                              issue_valid,
    input  logic [RISCV_V_OP_WIDTH-1:0]       op,
    input  logic [RISCV_V_REG_ADDR_WIDTH-1:0] vs1,
    input  logic [RISCV_V_REG_ADDR_WIDTH-1:0] vs2,
    input  logic [RISCV_V_REG_ADDR_WIDTH-1:0] vd,
    input  logic [RISCV_V_SEW_WIDTH-1:0]      vsew,
    input  logic [RISCV_V_VL_WIDTH-1:0]       vl,
    input  logic [RISCV_V_VL_WIDTH-1:0]       vstart,

    // Result port
    output logic                              done,
    output logic [RISCV_V_REG_ADDR_WIDTH-1:0] done_vd,
    output logic [RISCV_V_DATA_WIDTH-1:0]     done_data
);

    logic [RISCV_V_DATA_WIDTH-1:0]       rd_vs1;
    logic [RISCV_V_DATA_WIDTH-1:0]       rd_vs2;
    logic [RISCV_V_DATA_WIDTH-1:0]       rd_vd;
    logic [RISCV_V_NUM_VALID_OSIZES-1:0] ge_vec;
    logic [RISCV_V_NUM_BYTES_DATA-1:0]   dec_merge;
    logic [RISCV_V_NUM_BYTES_DATA-1:0]   dec_valid;

    // Stage 1
    logic                                s1_valid;
    logic [RISCV_V_OP_WIDTH-1:0]         s1_op;
    logic [RISCV_V_REG_ADDR_WIDTH-1:0]   s1_vd;
    logic [RISCV_V_DATA_WIDTH-1:0]       s1_srca;
    logic [RISCV_V_DATA_WIDTH-1:0]       s1_srcb;
    logic [RISCV_V_DATA_WIDTH-1:0]       s1_old;
    logic [RISCV_V_NUM_BYTES_DATA-1:0]   s1_merge;
    logic [RISCV_V_NUM_BYTES_DATA-1:0]   s1_byte_en;

    logic [RISCV_V_DATA_WIDTH-1:0]       alu_result;
    logic [RISCV_V_DATA_WIDTH-1:0]       merged;

    logic                                rf_we;
    logic [RISCV_V_REG_ADDR_WIDTH-1:0]   rf_waddr;
    logic [RISCV_V_DATA_WIDTH-1:0]       rf_wdata;

    logic [RISCV_V_SEW_WIDTH-1:0]        sew_shift;
    logic [RISCV_V_VL_WIDTH-1:0]         vl_limit;

    // Writeback owns the port while done is high
    assign rf_we    = done | wr_valid;
    assign rf_waddr = done ? done_vd : wr_addr;
    assign rf_wdata = done ? done_data : wr_data;

    riscv_v_regfile i_riscv_v_regfile (
        .clk     (clk),
        .rst_n   (rst_n),
        .raddr_a (vs1),
        .rdata_a (rd_vs1),
        .raddr_b (vs2),
        .rdata_b (rd_vs2),
        .raddr_c (vd),
        .rdata_c (rd_vd),
        .we      (rf_we),
        .waddr   (rf_waddr),
        .wdata   (rf_wdata)
    );

    riscv_v_decode_element i_riscv_v_decode_element (
        .vtype_vsew              (vsew),
        .vl                      (vl),
        .vstart                  (vstart),
        .dst_osize_vector        (),
        .is_greater_osize_vector (ge_vec),
        .merge                   (dec_merge),
        .valid                   (dec_valid)
    );

    // Issue stage
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            s1_op      <= op;
            s1_vd      <= vd;
            s1_srca    <= rd_vs1;
            s1_srcb    <= rd_vs2;
            s1_old     <= rd_vd;
            s1_merge   <= dec_merge;
            s1_byte_en <= dec_valid;
        end
    end

    riscv_v_lane_alu i_riscv_v_lane_alu (
        .op     (s1_op),
        .srca   (s1_srca),
        .srcb   (s1_srcb),
        .merge  (s1_merge),
        .result (alu_result)
    );

    // Inactive bytes keep the old destination contents
    always_comb begin
        for (int b = 0; b < RISCV_V_NUM_BYTES_DATA; b++) begin
            merged[b*8 +: 8] = s1_byte_en[b] ? alu_result[b*8 +: 8] : s1_old[b*8 +: 8];
        end
    end

    // Execute stage
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done <= 1'b0;
        end else begin
            done <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            done_vd   <= s1_vd;
            done_data <= merged;
        end
    end

    // log2 of the element size, taken from the thermometer
    always_comb begin
        sew_shift = '0;
        for (int w = 1; w < RISCV_V_NUM_VALID_OSIZES; w++) begin
            if (ge_vec[w]) begin
                sew_shift = RISCV_V_SEW_WIDTH'(w);
            end
        end
    end

    assign vl_limit = RISCV_V_VL_WIDTH'(RISCV_V_NUM_ELEMENTS_REG >> sew_shift);

    a_no_issue_during_preload : assert property (
        @(posedge clk) disable iff (!rst_n)
        !(issue_valid && wr_valid)
    ) else $error("exec: issue and preload in the same cycle");

    // vl bounded by the element count of the selected width
    a_vl_in_range : assert property (
        @(posedge clk) disable iff (!rst_n)
        issue_valid |-> (vl <= vl_limit)
    ) else $error("exec: vl %0d exceeds %0d elements", vl, vl_limit);

endmodule : riscv_v_exec_unit

/* verilog/riscv_v_lane_alu.sv */
//----------------------------------------------------------
// Byte-sliced vector ALU: add, sub, and, or, xor
// Carries cross byte boundaries only inside an element
//----------------------------------------------------------

module riscv_v_lane_alu
    import riscv_v_pkg::*;
(
    input  logic [RISCV_V_OP_WIDTH-1:0]       op,
    input  logic [RISCV_V_DATA_WIDTH-1:0]     srca,
    input  logic [RISCV_V_DATA_WIDTH-1:0]     srcb,
    input  logic [RISCV_V_NUM_BYTES_DATA-1:0] merge,
    output logic [RISCV_V_DATA_WIDTH-1:0]     result
);

    logic                          is_sub;
    logic [RISCV_V_DATA_WIDTH-1:0] srcb_add;
    logic [RISCV_V_DATA_WIDTH-1:0] sum;
    logic [RISCV_V_DATA_WIDTH-1:0] and_res;
    logic [RISCV_V_DATA_WIDTH-1:0] or_res;
    logic [RISCV_V_DATA_WIDTH-1:0] xor_res;

    // Subtract as a + ~b + 1
    assign is_sub   = (op == ALU_SUB);
    assign srcb_add = is_sub ? ~srcb : srcb;

    // Byte adder chain
    // A cleared merge bit restarts the carry with the element's start value
    always_comb begin
        logic       carry;
        logic [8:0] byte_sum;

        carry = is_sub;
        for (int b = 0; b < RISCV_V_NUM_BYTES_DATA; b++) begin
            byte_sum = {1'b0, srca[b*8 +: 8]} + {1'b0, srcb_add[b*8 +: 8]} + {8'd0, carry};
            sum[b*8 +: 8] = byte_sum[7:0];
            carry = merge[b] ? byte_sum[8] : is_sub;
        end
    end

    // Bitwise ops need no element boundaries
    assign and_res = srca & srcb;
    assign or_res  = srca | srcb;
    assign xor_res = srca ^ srcb;

    always_comb begin
        case (op)
            ALU_ADD,
            ALU_SUB: result = sum;
            ALU_AND: result = and_res;
            ALU_OR:  result = or_res;
            ALU_XOR: result = xor_res;
            default: result = '0;
        endcase
    end

    // Op comes from the stage 1 register, unknown until the first issue
    always_comb begin
        if (!$isunknown(op)) begin
            assert (op <= ALU_XOR)
                else $error("alu: illegal op code %0d", op);
        end
    end

endmodule : riscv_v_lane_alu

/* verilog/riscv_v_regfile.sv */
//----------------------------------------------------------
// Vector register file, eight 128-bit registers
// Three combinational reads, one synchronous write
//----------------------------------------------------------

module riscv_v_regfile
    import riscv_v_pkg::*;
(
    input  logic                              clk,
    input  logic                              rst_n,

    // Read ports
    input  logic [RISCV_V_REG_ADDR_WIDTH-1:0] raddr_a,
    output logic [RISCV_V_DATA_WIDTH-1:0]     rdata_a,
    input  logic [RISCV_V_REG_ADDR_WIDTH-1:0] raddr_b,
    output logic [RISCV_V_DATA_WIDTH-1:0]     rdata_b,
    input  logic [RISCV_V_REG_ADDR_WIDTH-1:0] raddr_c,
    output logic [RISCV_V_DATA_WIDTH-1:0]     rdata_c,

    // Write port
    input  logic                              we,
    input  logic [RISCV_V_REG_ADDR_WIDTH-1:0] waddr,
    input  logic [RISCV_V_DATA_WIDTH-1:0]     wdata
);

    logic [RISCV_V_DATA_WIDTH-1:0] regs [RISCV_V_NUM_REGS];

    // All registers start at zero
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < RISCV_V_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // Reads return the state before this edge's write
    // No bypass from the write port
    assign rdata_a = regs[raddr_a];
    assign rdata_b = regs[raddr_b];

    // Third port fetches the old destination value
    assign rdata_c = regs[raddr_c];

endmodule : riscv_v_regfile

/* verilog/riscv_v_decode_element.sv */
//----------------------------------------------------------
// Element decode: vsew to one-hot width vectors
// Per-byte merge mask and vstart/vl valid mask
//----------------------------------------------------------

module riscv_v_decode_element
    import riscv_v_pkg::*;
(
    input  logic [RISCV_V_SEW_WIDTH-1:0]        vtype_vsew,
    input  logic [RISCV_V_VL_WIDTH-1:0]         vl,
    input  logic [RISCV_V_VL_WIDTH-1:0]         vstart,
    output logic [RISCV_V_NUM_VALID_OSIZES-1:0] dst_osize_vector,
    output logic [RISCV_V_NUM_VALID_OSIZES-1:0] is_greater_osize_vector,
    output logic [RISCV_V_NUM_BYTES_DATA-1:0]   merge,
    output logic [RISCV_V_NUM_BYTES_DATA-1:0]   valid
);

    // Element i lies inside [vstart, vl)
    logic [RISCV_V_NUM_ELEMENTS_REG-1:0] elem_active;

    // One pattern per width, only the selected one is non-zero
    logic [RISCV_V_NUM_BYTES_DATA-1:0] merge_osize [RISCV_V_NUM_VALID_OSIZES];
    logic [RISCV_V_NUM_BYTES_DATA-1:0] valid_osize [RISCV_V_NUM_VALID_OSIZES];

    // One-hot width
    assign dst_osize_vector[0] = (vtype_vsew == OSIZE_8);
    assign dst_osize_vector[1] = (vtype_vsew == OSIZE_16);
    assign dst_osize_vector[2] = (vtype_vsew == OSIZE_32);
    assign dst_osize_vector[3] = (vtype_vsew == OSIZE_64);
    assign dst_osize_vector[4] = (vtype_vsew == OSIZE_128);

    // Thermometer, bit w set when the element is at least 2**w bytes
    assign is_greater_osize_vector[0] = 1'b1;

    generate
        for (genvar w = 1; w < RISCV_V_NUM_VALID_OSIZES; w++) begin : gen_is_greater
            assign is_greater_osize_vector[w] =
                |dst_osize_vector[RISCV_V_NUM_VALID_OSIZES-1:w];
        end
    endgenerate

    // Element range comparators
    always_comb begin
        for (int i = 0; i < RISCV_V_NUM_ELEMENTS_REG; i++) begin
            elem_active[i] = (vstart <= RISCV_V_VL_WIDTH'(i)) &&
                             (vl > RISCV_V_VL_WIDTH'(i));
        end
    end

    // Per-width patterns
    // Merge bit b links byte b to byte b+1 inside one element
    always_comb begin
        for (int w = 0; w < RISCV_V_NUM_VALID_OSIZES; w++) begin
            merge_osize[w] = '0;
            valid_osize[w] = '0;
            for (int b = 0; b < RISCV_V_NUM_BYTES_DATA; b++) begin
                // Last byte of an element breaks the chain
                if (((b + 1) % (1 << w)) != 0) begin
                    merge_osize[w][b] = dst_osize_vector[w];
                end
                // Element index is the byte index over the element size
                valid_osize[w][b] = dst_osize_vector[w] & elem_active[b >> w];
            end
        end
    end

    // OR of all width patterns
    always_comb begin
        merge = '0;
        valid = '0;
        for (int w = 0; w < RISCV_V_NUM_VALID_OSIZES; w++) begin
            merge |= merge_osize[w];
            valid |= valid_osize[w];
        end
    end

    // vsew out of range leaves every mask empty
    always_comb begin
        if (!$isunknown(vtype_vsew)) begin
            assert (vtype_vsew <= OSIZE_128)
                else $error("decode: vsew %0d is not a legal width", vtype_vsew);
            assert ($onehot(dst_osize_vector))
                else $error("decode: width vector %b not one-hot", dst_osize_vector);
        end
    end

endmodule : riscv_v_decode_element

/* verilog/riscv_v_pkg.sv */
//----------------------------------------------------------
// Shared constants of the vector execution unit
// Register geometry, element width codes, ALU op codes
//----------------------------------------------------------

package riscv_v_pkg;

    // Vector register geometry
    localparam int RISCV_V_NUM_BYTES_DATA = 16;
    localparam int RISCV_V_DATA_WIDTH     = RISCV_V_NUM_BYTES_DATA * 8;

    // Supported element widths, 8 up to 128 bits
    localparam int RISCV_V_NUM_VALID_OSIZES = 5;

    // Largest element count, reached at 8-bit elements
    localparam int RISCV_V_NUM_ELEMENTS_REG = RISCV_V_NUM_BYTES_DATA;

    // vl and vstart must hold the value 16 itself
    localparam int RISCV_V_VL_WIDTH = 5;

    // Register file size
    localparam int RISCV_V_NUM_REGS       = 8;
    localparam int RISCV_V_REG_ADDR_WIDTH = 3;

    // Field widths of vsew and op
    localparam int RISCV_V_SEW_WIDTH = 3;
    localparam int RISCV_V_OP_WIDTH  = 3;

    // vsew encoding, log2 of the element size in bytes
    localparam logic [RISCV_V_SEW_WIDTH-1:0] OSIZE_8   = 3'd0;
    localparam logic [RISCV_V_SEW_WIDTH-1:0] OSIZE_16  = 3'd1;
    localparam logic [RISCV_V_SEW_WIDTH-1:0] OSIZE_32  = 3'd2;
    localparam logic [RISCV_V_SEW_WIDTH-1:0] OSIZE_64  = 3'd3;
    localparam logic [RISCV_V_SEW_WIDTH-1:0] OSIZE_128 = 3'd4;

    // Operation encoding
    localparam logic [RISCV_V_OP_WIDTH-1:0] ALU_ADD = 3'd0;
    localparam logic [RISCV_V_OP_WIDTH-1:0] ALU_SUB = 3'd1;
    localparam logic [RISCV_V_OP_WIDTH-1:0] ALU_AND = 3'd2;
    localparam logic [RISCV_V_OP_WIDTH-1:0] ALU_OR  = 3'd3;
    localparam logic [RISCV_V_OP_WIDTH-1:0] ALU_XOR = 3'd4;

    // Codes 5 to 7 are reserved and never issued

endpackage : riscv_v_pkg
